//--- mcu_pkg.sv
package mcu_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    localparam int ADDR_W   = 23;          // Word address, A[23:1]
    localparam int DATA_W   = 8;           // Register port is byte wide
    localparam int NUM_CHAN = 3;

    // Channel indices
    localparam int CHAN_VIDEO = 0;
    localparam int CHAN_SOUND = 1;
    localparam int CHAN_DMA   = 2;

    // ========================================================================
    // Register map
    // ========================================================================

    localparam logic [7:0] DEV_PAGE = 8'hFF;   // A[23:16] of device space

    // Page byte A[15:8] per channel, entry 0 is video
    localparam logic [NUM_CHAN-1:0][7:0] CHAN_PAGE = {
        8'h86,                                  // Floppy DMA
        8'h89,                                  // Sound DMA
        8'h82                                   // Video
    };

    // Word index within a page, taken from A[3:1]
    localparam logic [2:0] REG_BASE_HI  = 3'd0;
    localparam logic [2:0] REG_BASE_MID = 3'd1;
    localparam logic [2:0] REG_BASE_LO  = 3'd2;
    localparam logic [2:0] REG_CNT_HI   = 3'd3;
    localparam logic [2:0] REG_CNT_MID  = 3'd4;
    localparam logic [2:0] REG_CNT_LO   = 3'd5;

    // ========================================================================
    // Bus error timeout
    // ========================================================================

    localparam int BERR_CYCLES = 64;           // clk32 edges without an answer
    localparam int BERR_CNT_W  = 7;

    // ========================================================================
    // Types
    // ========================================================================

    // Current owner of the RAM bus
    typedef enum logic [2:0] {
        SLOT_CPU     = 3'd0,
        SLOT_VIDEO   = 3'd1,
        SLOT_SOUND   = 3'd2,
        SLOT_DMA     = 3'd3,
        SLOT_REFRESH = 3'd4
    } bus_slot_e;

    // Byte lane of a pointer register
    typedef enum logic [1:0] {
        LANE_HI  = 2'd0,                       // A[23:16]
        LANE_MID = 2'd1,                       // A[15:8]
        LANE_LO  = 2'd2                        // A[7:1], bit 0 reads zero
    } lane_e;

endpackage

//--- mcu_bus_ctrl.sv
module mcu_bus_ctrl (
    input  logic                                 clk32,
    input  logic                                 porb,
    input  logic                                 as_n_i,
    input  logic                                 rw_i,
    input  logic                                 lds_n_i,
    input  logic [mcu_pkg::ADDR_W:1]             addr_i,
    input  logic [mcu_pkg::DATA_W-1:0]           data_i,
    output logic                                 dtack_n_o,
    output logic                                 berr_n_o,
    output logic [mcu_pkg::NUM_CHAN-1:0]         wr_en_o,
    output mcu_pkg::lane_e                       wr_lane_o,
    output logic [mcu_pkg::DATA_W-1:0]           wr_data_o,
    output logic                                 rd_valid_o,
    output logic [1:0]                           rd_chan_o,
    output mcu_pkg::lane_e                       rd_lane_o,
    output logic                                 rd_cnt_o
);

    logic [2:0]                        reg_idx;
    logic                              page_hit;
    logic [1:0]                        chan_sel;
    mcu_pkg::lane_e                    lane_sel;
    logic                              hit;
    logic                              wr_fire;
    logic                              dtack_q;
    logic                              wr_done_q;
    logic [mcu_pkg::BERR_CNT_W-1:0]    berr_cnt_q;
    logic                              berr_hit;

    // ========================================================================
    // Address decode
    // ========================================================================

    assign reg_idx = addr_i[3:1];

    // Channel page lookup
    always_comb begin
        page_hit = 1'b0;
        chan_sel = 2'd0;
        for (int c = 0; c < mcu_pkg::NUM_CHAN; c++) begin
            if (addr_i[15:8] == mcu_pkg::CHAN_PAGE[c]) begin
                page_hit = 1'b1;
                chan_sel = 2'(c);
            end
        end
    end

    // Base and counter share the lane order
    always_comb begin
        case (reg_idx)
            mcu_pkg::REG_BASE_HI,  mcu_pkg::REG_CNT_HI:  lane_sel = mcu_pkg::LANE_HI;
            mcu_pkg::REG_BASE_MID, mcu_pkg::REG_CNT_MID: lane_sel = mcu_pkg::LANE_MID;
            default:                                     lane_sel = mcu_pkg::LANE_LO;
        endcase
    end

    assign hit = !as_n_i && !lds_n_i
              && addr_i[23:16] == mcu_pkg::DEV_PAGE
              && page_hit
              && addr_i[7:4] == 4'h0
              && reg_idx <= mcu_pkg::REG_CNT_LO;

    assign wr_fire = hit && !rw_i && !wr_done_q;   // Once per strobe

    assign wr_en_o   = wr_fire ? mcu_pkg::NUM_CHAN'(1) << chan_sel : '0;
    assign wr_lane_o = lane_sel;
    assign wr_data_o = data_i;

    assign rd_valid_o = hit && rw_i;
    assign rd_chan_o  = chan_sel;
    assign rd_lane_o  = lane_sel;
    assign rd_cnt_o   = reg_idx >= mcu_pkg::REG_CNT_HI;

    // ========================================================================
    // Strobe handshake
    // ========================================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            dtack_q   <= 1'b0;
            wr_done_q <= 1'b0;
        end else if (as_n_i) begin    // Strobe released
            dtack_q   <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            if (hit)
                dtack_q <= 1'b1;
            if (wr_fire)
                wr_done_q <= 1'b1;
        end
    end

    assign dtack_n_o = !dtack_q;

    // Bus error timeout, saturates at the limit
    assign berr_hit = berr_cnt_q == mcu_pkg::BERR_CNT_W'(mcu_pkg::BERR_CYCLES);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            berr_cnt_q <= '0;
        end else if (as_n_i || hit || dtack_q) begin
            berr_cnt_q <= '0;
        end else if (!berr_hit) begin
            berr_cnt_q <= berr_cnt_q + 1'b1;
        end
    end

    assign berr_n_o = !berr_hit;

    // A strobe ends in DTACK or in a bus error, never both
    a_ack_excl: assert property (@(posedge clk32) disable iff (!porb)
        !(!dtack_n_o && !berr_n_o));

endmodule

//--- addr_channel.sv
module addr_channel #(
    parameter mcu_pkg::bus_slot_e CHAN_SLOT = mcu_pkg::SLOT_VIDEO
) (
    input  logic                          clk32,
    input  logic                          porb,
    input  logic                          wr_en_i,
    input  mcu_pkg::lane_e                wr_lane_i,
    input  logic [mcu_pkg::DATA_W-1:0]    wr_data_i,
    input  logic                          restart_i,
    input  mcu_pkg::bus_slot_e            slot_i,
    input  logic                          cycle_end_i,
    output logic [mcu_pkg::ADDR_W:1]      base_o,
    output logic [mcu_pkg::ADDR_W:1]      count_o
);

    logic [mcu_pkg::ADDR_W:1] base_q;
    logic [mcu_pkg::ADDR_W:1] cnt_q;
    logic [mcu_pkg::ADDR_W:1] base_wr;
    logic [mcu_pkg::ADDR_W:1] cnt_wr;
    logic                     step;

    // Memory cycle finished in our own slot
    assign step = cycle_end_i && slot_i == CHAN_SLOT;

    // ========================================================================
    // Lane merge
    // ========================================================================

    // The written byte replaces one lane of both registers
    always_comb begin
        base_wr = base_q;
        cnt_wr  = cnt_q;
        case (wr_lane_i)
            mcu_pkg::LANE_HI: begin
                base_wr[23:16] = wr_data_i;
                cnt_wr[23:16]  = wr_data_i;
            end
            mcu_pkg::LANE_MID: begin
                base_wr[15:8] = wr_data_i;
                cnt_wr[15:8]  = wr_data_i;
            end
            mcu_pkg::LANE_LO: begin
                base_wr[7:1] = wr_data_i[7:1];   // Word aligned
                cnt_wr[7:1]  = wr_data_i[7:1];
            end
            default: begin
                base_wr = base_q;
                cnt_wr  = cnt_q;
            end
        endcase
    end

    // ========================================================================
    // Base register and word counter
    // ========================================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            base_q <= '0;
        end else if (wr_en_i) begin
            base_q <= base_wr;
        end
    end

    // Write wins over restart, restart over step
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            cnt_q <= '0;
        end else if (wr_en_i) begin
            cnt_q <= cnt_wr;
        end else if (restart_i) begin
            cnt_q <= base_q;
        end else if (step) begin
            cnt_q <= cnt_q + 1'b1;               // Wraps at ADDR_W bits
        end
    end

    assign base_o  = base_q;
    assign count_o = cnt_q;

    // Counter is frozen unless something asks it to move
    a_cnt_hold: assert property (@(posedge clk32) disable iff (!porb)
        !(wr_en_i || restart_i || step) |=> $stable(count_o));

endmodule

//--- mcu_bus_mux.sv
module mcu_bus_mux (
    input  mcu_pkg::bus_slot_e                                slot_i,
    input  logic [mcu_pkg::ADDR_W:1]                          addr_i,
    input  logic [mcu_pkg::NUM_CHAN-1:0][mcu_pkg::ADDR_W:1]   base_i,
    input  logic [mcu_pkg::NUM_CHAN-1:0][mcu_pkg::ADDR_W:1]   count_i,
    input  logic                                              rd_valid_i,
    input  logic [1:0]                                        rd_chan_i,
    input  mcu_pkg::lane_e                                    rd_lane_i,
    input  logic                                              rd_cnt_i,
    output logic [mcu_pkg::ADDR_W:1]                          ram_addr_o,
    output logic [mcu_pkg::DATA_W-1:0]                        data_o
);

    logic [mcu_pkg::ADDR_W:1] rd_word;
    logic                     rd_ok;

    // ========================================================================
    // RAM address by bus owner
    // ========================================================================

    always_comb begin
        case (slot_i)
            mcu_pkg::SLOT_CPU:   ram_addr_o = addr_i;
            mcu_pkg::SLOT_VIDEO: ram_addr_o = count_i[mcu_pkg::CHAN_VIDEO];
            mcu_pkg::SLOT_SOUND: ram_addr_o = count_i[mcu_pkg::CHAN_SOUND];
            mcu_pkg::SLOT_DMA:   ram_addr_o = count_i[mcu_pkg::CHAN_DMA];
            default:             ram_addr_o = '0;     // Refresh cycle
        endcase
    end

    // ========================================================================
    // Register read return
    // ========================================================================

    assign rd_ok = rd_valid_i && rd_chan_i < 2'(mcu_pkg::NUM_CHAN);

    always_comb begin
        rd_word = '0;
        if (rd_ok) begin
            rd_word = rd_cnt_i ? count_i[rd_chan_i] : base_i[rd_chan_i];
        end
    end

    // Idle bus floats high
    always_comb begin
        data_o = 8'hFF;
        if (rd_ok) begin
            case (rd_lane_i)
                mcu_pkg::LANE_HI:  data_o = rd_word[23:16];
                mcu_pkg::LANE_MID: data_o = rd_word[15:8];
                mcu_pkg::LANE_LO:  data_o = {rd_word[7:1], 1'b0};
                default:           data_o = 8'hFF;
            endcase
        end
    end

endmodule

//--- stmcu_addr_unit.sv
module stmcu_addr_unit (
    input  logic                          clk32,
    input  logic                          porb,
    input  logic                          as_n_i,
    input  logic                          rw_i,
    input  logic                          lds_n_i,
    input  logic [mcu_pkg::ADDR_W:1]      addr_i,
    input  logic [mcu_pkg::DATA_W-1:0]    data_i,
    input  mcu_pkg::bus_slot_e            slot_i,
    input  logic                          cycle_end_i,
    input  logic [mcu_pkg::NUM_CHAN-1:0]  restart_i,
    output logic                          dtack_n_o,
    output logic                          berr_n_o,
    output logic [mcu_pkg::DATA_W-1:0]    data_o,
    output logic [mcu_pkg::ADDR_W:1]      ram_addr_o
);

    logic [mcu_pkg::NUM_CHAN-1:0]                    wr_en;
    mcu_pkg::lane_e                                  wr_lane;
    logic [mcu_pkg::DATA_W-1:0]                      wr_data;
    logic                                            rd_valid;
    logic [1:0]                                      rd_chan;
    mcu_pkg::lane_e                                  rd_lane;
    logic                                            rd_cnt;
    logic [mcu_pkg::NUM_CHAN-1:0][mcu_pkg::ADDR_W:1] base;
    logic [mcu_pkg::NUM_CHAN-1:0][mcu_pkg::ADDR_W:1] count;

    // ========================================================================
    // CPU register port
    // ========================================================================

    mcu_bus_ctrl u_bus_ctrl (
        .clk32      (clk32),
        .porb       (porb),
        .as_n_i     (as_n_i),
        .rw_i       (rw_i),
        .lds_n_i    (lds_n_i),
        .addr_i     (addr_i),
        .data_i     (data_i),
        .dtack_n_o  (dtack_n_o),
        .berr_n_o   (berr_n_o),
        .wr_en_o    (wr_en),
        .wr_lane_o  (wr_lane),
        .wr_data_o  (wr_data),
        .rd_valid_o (rd_valid),
        .rd_chan_o  (rd_chan),
        .rd_lane_o  (rd_lane),
        .rd_cnt_o   (rd_cnt)
    );

    // ========================================================================
    // Address channels, slot follows channel index
    // ========================================================================

    for (genvar ch = 0; ch < mcu_pkg::NUM_CHAN; ch++) begin : g_chan
        addr_channel #(
            .CHAN_SLOT (mcu_pkg::bus_slot_e'(mcu_pkg::SLOT_VIDEO + ch))
        ) u_chan (
            .clk32       (clk32),
            .porb        (porb),
            .wr_en_i     (wr_en[ch]),
            .wr_lane_i   (wr_lane),
            .wr_data_i   (wr_data),
            .restart_i   (restart_i[ch]),
            .slot_i      (slot_i),
            .cycle_end_i (cycle_end_i),
            .base_o      (base[ch]),
            .count_o     (count[ch])
        );
    end

    mcu_bus_mux u_bus_mux (
        .slot_i     (slot_i),
        .addr_i     (addr_i),
        .base_i     (base),
        .count_i    (count),
        .rd_valid_i (rd_valid),
        .rd_chan_i  (rd_chan),
        .rd_lane_i  (rd_lane),
        .rd_cnt_i   (rd_cnt),
        .ram_addr_o (ram_addr_o),
        .data_o     (data_o)   // Read data back to CPU
    );

endmodule

//--- tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, channel, register index / step count / slot, write data,
// check flag, expected value (read data or ram_addr_o, used when the flag is set)

localparam int NUM_VEC = 38;

localparam vec_t VECTORS [NUM_VEC] = '{
    // Reset state
    '{OP_IDLE,      2'd0, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd0, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd2, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    // Video base from fixed bytes, bit 0 of the low lane is dropped
    '{OP_WRITE,     2'd0, 3'd0, 8'h12, 1'b0, 23'h00_0000},
    '{OP_WRITE,     2'd0, 3'd1, 8'h34, 1'b0, 23'h00_0000},
    '{OP_WRITE,     2'd0, 3'd2, 8'h57, 1'b0, 23'h00_0000},
    '{OP_READ,      2'd0, 3'd2, 8'h00, 1'b1, 23'h00_0056},
    '{OP_READ,      2'd0, 3'd3, 8'h00, 1'b1, 23'h00_0012},
    '{OP_READ,      2'd0, 3'd5, 8'h00, 1'b1, 23'h00_0056},
    // Random bases on sound and floppy DMA
    '{OP_WRITE_RND, 2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_WRITE_RND, 2'd1, 3'd1, 8'h00, 1'b0, 23'h00_0000},
    '{OP_WRITE_RND, 2'd1, 3'd2, 8'h00, 1'b0, 23'h00_0000},
    '{OP_WRITE_RND, 2'd2, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_WRITE_RND, 2'd2, 3'd1, 8'h00, 1'b0, 23'h00_0000},
    '{OP_WRITE_RND, 2'd2, 3'd2, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd2, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    // Low lane of all ones carries into the middle lane
    '{OP_WRITE,     2'd0, 3'd2, 8'hFF, 1'b0, 23'h00_0000},
    '{OP_STEP,      2'd0, 3'd1, 8'h00, 1'b0, 23'h00_0000},
    '{OP_READ,      2'd0, 3'd4, 8'h00, 1'b1, 23'h00_0035},
    '{OP_READ,      2'd0, 3'd5, 8'h00, 1'b1, 23'h00_0000},
    '{OP_DUMP,      2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_STEP,      2'd1, 3'd3, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    // Restart brings the base back
    '{OP_RESTART,   2'd0, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_READ,      2'd0, 3'd5, 8'h00, 1'b1, 23'h00_00FE},
    '{OP_RESTART,   2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd1, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    // RAM address by bus owner
    '{OP_STEP,      2'd2, 3'd2, 8'h00, 1'b0, 23'h00_0000},
    '{OP_SLOT,      2'd0, mcu_pkg::SLOT_CPU,     8'h00, 1'b1, 23'h2B_5A5A},
    '{OP_SLOT,      2'd0, mcu_pkg::SLOT_VIDEO,   8'h00, 1'b0, 23'h00_0000},
    '{OP_SLOT,      2'd0, mcu_pkg::SLOT_SOUND,   8'h00, 1'b0, 23'h00_0000},
    '{OP_SLOT,      2'd0, mcu_pkg::SLOT_DMA,     8'h00, 1'b0, 23'h00_0000},
    '{OP_SLOT,      2'd0, mcu_pkg::SLOT_REFRESH, 8'h00, 1'b1, 23'h00_0000},
    // Floppy DMA counter back to its base after the steps
    '{OP_RESTART,   2'd2, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    '{OP_DUMP,      2'd2, 3'd0, 8'h00, 1'b0, 23'h00_0000},
    // Unmapped page ends in a bus error
    '{OP_BERR,      2'd0, 3'd0, 8'h00, 1'b0, 23'h00_0000}
};

`endif

//--- tb_stmcu_addr_unit.sv
module tb_stmcu_addr_unit;

    typedef enum logic [3:0] {
        OP_IDLE,                    // Handshake outputs at rest
        OP_DUMP,                    // All six registers of a channel
        OP_WRITE,
        OP_WRITE_RND,
        OP_READ,
        OP_STEP,                    // arg is the number of memory cycles
        OP_RESTART,
        OP_SLOT,                    // arg is the bus slot
        OP_BERR
    } op_e;

    typedef struct packed {
        op_e                      op;
        logic [1:0]               chan;
        logic [2:0]               arg;
        logic [7:0]               data;
        logic                     chk;     // Also compare with exp
        logic [mcu_pkg::ADDR_W:1] exp;
    } vec_t;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_WAIT     = 8;
    localparam int BERR_WAIT    = 70;
    localparam logic [mcu_pkg::ADDR_W:1] CPU_ADDR = 23'h2B_5A5A;

    `include "tb_vectors.svh"

    logic                         clk32;
    logic                         porb;
    logic                         as_n_i;
    logic                         rw_i;
    logic                         lds_n_i;
    logic [mcu_pkg::ADDR_W:1]     addr_i;
    logic [7:0]                   data_i;
    mcu_pkg::bus_slot_e           slot_i;
    logic                         cycle_end_i;
    logic [mcu_pkg::NUM_CHAN-1:0] restart_i;
    logic                         dtack_n_o;
    logic                         berr_n_o;
    logic [7:0]                   data_o;
    logic [mcu_pkg::ADDR_W:1]     ram_addr_o;

    // Reference model of base and counter per channel
    logic [mcu_pkg::ADDR_W:1] base_m [mcu_pkg::NUM_CHAN];
    logic [mcu_pkg::ADDR_W:1] cnt_m  [mcu_pkg::NUM_CHAN];
    integer                   seed;

    stmcu_addr_unit dut_i (.*);

    initial begin
        clk32 = 1'b0;
        forever #(CLK_PERIOD / 2) clk32 = ~clk32;
    end

    // Each table row gets at most 200 cycles
    initial begin
        repeat (RESET_CYCLES + NUM_VEC * 200) @(posedge clk32);
        $display("Watchdog expired before the table was finished");
        stop_run();
    end

    // ========================================================================
    // Checking and model helpers
    // ========================================================================

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, want);
            stop_run();
        end
    endtask

    // Lane as the CPU reads it, bit 0 of the low lane is zero
    function automatic logic [7:0] read_model(input int ch, input int idx);
        logic [mcu_pkg::ADDR_W:1] word;
        word = (idx < 3) ? base_m[ch] : cnt_m[ch];
        case (idx % 3)
            0:       return word[23:16];
            1:       return word[15:8];
            default: return {word[7:1], 1'b0};
        endcase
    endfunction

    function automatic logic [mcu_pkg::ADDR_W:1] put_lane(input logic [mcu_pkg::ADDR_W:1] word,
                                                          input int idx, input logic [7:0] d);
        case (idx % 3)
            0:       word[23:16] = d;
            1:       word[15:8]  = d;
            default: word[7:1]   = d[7:1];
        endcase
        return word;
    endfunction

    function automatic mcu_pkg::bus_slot_e slot_of(input int ch);
        case (ch)
            mcu_pkg::CHAN_VIDEO: return mcu_pkg::SLOT_VIDEO;
            mcu_pkg::CHAN_SOUND: return mcu_pkg::SLOT_SOUND;
            default:             return mcu_pkg::SLOT_DMA;
        endcase
    endfunction

    function automatic logic [mcu_pkg::ADDR_W:1] ram_model(input mcu_pkg::bus_slot_e s);
        case (s)
            mcu_pkg::SLOT_CPU:   return CPU_ADDR;
            mcu_pkg::SLOT_VIDEO: return cnt_m[mcu_pkg::CHAN_VIDEO];
            mcu_pkg::SLOT_SOUND: return cnt_m[mcu_pkg::CHAN_SOUND];
            mcu_pkg::SLOT_DMA:   return cnt_m[mcu_pkg::CHAN_DMA];
            default:             return '0;     // Refresh
        endcase
    endfunction

    // ========================================================================
    // Bus cycles
    // ========================================================================

    // A write keeps the strobe one extra cycle with new data on the bus
    task automatic bus_access(input int ch, input int idx, input logic wr,
                              input logic [7:0] wd, output logic [7:0] rd);
        int waited;
        @(negedge clk32);
        addr_i  = {mcu_pkg::DEV_PAGE, mcu_pkg::CHAN_PAGE[ch], 4'h0, 3'(idx)};
        rw_i    = !wr;
        data_i  = wd;
        as_n_i  = 1'b0;
        lds_n_i = 1'b0;
        waited  = 0;
        @(negedge clk32);
        while (dtack_n_o && waited < ACK_WAIT) begin
            @(negedge clk32);
            waited++;
        end
        if (dtack_n_o) begin
            $display("DTACK never arrived for channel %0d register %0d", ch, idx);
            stop_run();
        end
        compare_value("dtack latency", waited, 0);
        compare_value("berr_n_o", berr_n_o, 1);
        rd = data_o;
        if (wr) begin
            data_i = ~wd;                       // Would show if written twice
            @(negedge clk32);
            compare_value("dtack_n_o held", dtack_n_o, 0);
        end
        as_n_i  = 1'b1;
        lds_n_i = 1'b1;
        rw_i    = 1'b1;
        @(negedge clk32);
        compare_value("dtack_n_o", dtack_n_o, 1);
    endtask

    task automatic read_check(input int ch, input int idx, input logic chk,
                              input logic [7:0] want);
        logic [7:0] rd;
        bus_access(ch, idx, 1'b0, 8'h00, rd);
        compare_value($sformatf("data_o ch%0d reg%0d", ch, idx), rd, read_model(ch, idx));
        if (chk)
            compare_value($sformatf("data_o ch%0d reg%0d", ch, idx), rd, want);
    endtask

    task automatic bus_error_check();
        int waited;
        @(negedge clk32);
        addr_i  = {mcu_pkg::DEV_PAGE, 8'h83, 4'h0, 3'd0};   // No channel here
        rw_i    = 1'b1;
        as_n_i  = 1'b0;
        lds_n_i = 1'b0;
        waited  = 0;
        while (berr_n_o && waited < BERR_WAIT) begin
            @(negedge clk32);
            waited++;
            compare_value("dtack_n_o", dtack_n_o, 1);
        end
        if (berr_n_o) begin
            $display("Bus error did not arrive within %0d cycles", BERR_WAIT);
            stop_run();
        end
        compare_value("bus error delay", waited, mcu_pkg::BERR_CYCLES);
        as_n_i  = 1'b1;
        lds_n_i = 1'b1;
        @(negedge clk32);
        compare_value("berr_n_o", berr_n_o, 1);
    endtask

    task automatic apply_vector(input vec_t v);
        logic [7:0] wd;
        logic [7:0] rd;
        int         r;
        case (v.op)
            OP_IDLE: begin
                compare_value("dtack_n_o", dtack_n_o, 1);
                compare_value("berr_n_o", berr_n_o, 1);
            end
            OP_DUMP: begin
                for (r = 0; r < 6; r++)
                    read_check(v.chan, r, 1'b0, 8'h00);
            end
            OP_WRITE, OP_WRITE_RND: begin
                wd = (v.op == OP_WRITE) ? v.data : 8'($random(seed));
                bus_access(v.chan, v.arg, 1'b1, wd, rd);
                base_m[v.chan] = put_lane(base_m[v.chan], v.arg, wd);
                cnt_m[v.chan]  = put_lane(cnt_m[v.chan], v.arg, wd);
            end
            OP_READ: read_check(v.chan, v.arg, v.chk, v.exp[8:1]);
            OP_STEP: begin
                @(negedge clk32);
                slot_i      = slot_of(v.chan);
                cycle_end_i = 1'b1;
                repeat (v.arg) @(negedge clk32);
                cycle_end_i = 1'b0;
                slot_i      = mcu_pkg::SLOT_CPU;
                cnt_m[v.chan] = cnt_m[v.chan] + v.arg;     // Wraps at 23 bits
            end
            OP_RESTART: begin
                @(negedge clk32);
                restart_i[v.chan] = 1'b1;
                @(negedge clk32);
                restart_i = '0;
                cnt_m[v.chan] = base_m[v.chan];
            end
            OP_SLOT: begin
                @(negedge clk32);
                slot_i = mcu_pkg::bus_slot_e'(v.arg);
                addr_i = CPU_ADDR;
                @(negedge clk32);
                compare_value($sformatf("ram_addr_o slot %0d", v.arg), ram_addr_o,
                              ram_model(slot_i));
                if (v.chk)
                    compare_value($sformatf("ram_addr_o slot %0d", v.arg), ram_addr_o, v.exp);
                slot_i = mcu_pkg::SLOT_CPU;
            end
            OP_BERR: bus_error_check();
            default: begin
                $display("Unknown operation %0d in the stimulus table", v.op);
                stop_run();
            end
        endcase
    endtask

    initial begin
        int i;
        seed        = 32'hdbc8_ecbe;
        porb        = 1'b0;
        as_n_i      = 1'b1;
        rw_i        = 1'b1;
        lds_n_i     = 1'b1;
        addr_i      = '0;
        data_i      = '0;
        slot_i      = mcu_pkg::SLOT_CPU;
        cycle_end_i = 1'b0;
        restart_i   = '0;
        for (i = 0; i < mcu_pkg::NUM_CHAN; i++) begin
            base_m[i] = '0;
            cnt_m[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk32);
        @(negedge clk32);
        porb = 1'b1;
        for (i = 0; i < NUM_VEC; i++)
            apply_vector(VECTORS[i]);
        $display("All tests passed");
        $finish;
    end

endmodule

//--- stmcu_addr_unit.f
+incdir+.
mcu_pkg.sv
mcu_bus_ctrl.sv
addr_channel.sv
mcu_bus_mux.sv
stmcu_addr_unit.sv
tb_stmcu_addr_unit.sv

//--- Bender.yml
package:
  name: stmcu_addr_unit

sources:
  - include_dirs:
      - .
    files:
      - mcu_pkg.sv
      - mcu_bus_ctrl.sv
      - addr_channel.sv
      - mcu_bus_mux.sv
      - stmcu_addr_unit.sv
      - target: simulation
        files:
          - tb_stmcu_addr_unit.sv
